// File: src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data word and instruction share one width
`define CPU_DATA_WIDTH 16

// General register count
`define CPU_REG_COUNT 16

// Instruction memory words and the flash address that reaches them
`define CPU_IMEM_DEPTH 1024
`define CPU_FLASH_ADDR_WIDTH 10

`endif

// File: src/isaPkg.sv
package isaPkg;

    // Major opcode in instruction bits 15..12
    typedef enum logic [3:0] {
        opNop        = 4'h0,
        opAlu        = 4'h1,
        opAluImm     = 4'h2,
        opLui        = 4'h3,
        opBranchZero = 4'h4,
        opJumpLink   = 4'h5,
        opHalt       = 4'hF
    } majorOpE;

    // ALU operation in bits 3..0 of opAlu
    typedef enum logic [3:0] {
        aluAdd   = 4'h0,
        aluSub   = 4'h1,
        aluAnd   = 4'h2,
        aluOr    = 4'h3,
        aluXor   = 4'h4,
        aluShl   = 4'h5,
        aluShr   = 4'h6,
        aluPassB = 4'h7
    } aluOpE;

    // Immediate in bits 7..0 overlaps regB and the ALU op
    typedef logic [7:0] immT;

    // regA is both destination and source A
    typedef struct packed {
        majorOpE    op;
        logic [3:0] regA;
        logic [3:0] regB;
        aluOpE      aluOp;
    } instFieldsT;

endpackage

// File: src/corePkg.sv
`include "cpu_settings.svh"

package corePkg;

    // One data word
    typedef logic [`CPU_DATA_WIDTH-1:0] dataT;

    // Register number
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regAddrT;

    // Instruction address as wide as the flash address
    typedef logic [`CPU_FLASH_ADDR_WIDTH-1:0] pcT;

endpackage

// File: src/registerFile.sv
`timescale 1ns/1ns

`include "cpu_settings.svh"

module registerFile (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::regAddrT readAddrA,
    input  corePkg::regAddrT readAddrB,
    output corePkg::dataT    readDataA,
    output corePkg::dataT    readDataB,
    input  logic             wrEn,
    input  corePkg::regAddrT wrAddr,
    input  corePkg::dataT    wrData
);

    corePkg::dataT regs [`CPU_REG_COUNT];

    // All registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see the old value during a write and decode forwards around it
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

// File: src/fetchStage.sv
`timescale 1ns/1ns

`include "cpu_settings.svh"

module fetchStage (
    input  logic          clk,
    input  logic          rst,
    input  logic          systemEn,
    input  logic          instFlashEn,
    input  corePkg::pcT   flashAddr,
    input  corePkg::dataT flashData,
    input  logic          fetchHold,
    input  logic          redirectValid,
    input  corePkg::pcT   redirectPc,
    output logic          instValid,
    output corePkg::dataT instWord,
    output corePkg::pcT   instPc
);

    corePkg::dataT instMem [`CPU_IMEM_DEPTH];
    corePkg::pcT   pc;
    logic          advance;

    // Decode takes the presented word in exactly the cycles where fetch moves on
    assign advance = systemEn && !fetchHold;

    // Flash port writes regardless of the run state
    always_ff @(posedge clk) begin
        if (instFlashEn) begin
            instMem[flashAddr] <= flashData;
        end
    end

    // Redirect wins over hold and over a stopped system
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            instValid <= 1'b0;
        end else if (redirectValid) begin
            pc        <= redirectPc;
            instValid <= 1'b0;
        end else if (advance) begin
            pc        <= pc + corePkg::pcT'(1);
            instValid <= 1'b1;
        end
    end

    // Synchronous read, tagged with the pc it came from
    always_ff @(posedge clk) begin
        if (advance && !redirectValid) begin
            instWord <= instMem[pc];
            instPc   <= pc;
        end
    end

    // A redirect always leaves one empty cycle before the target word
    redirectGap: assert property (
        @(posedge clk) disable iff (rst)
        redirectValid |=> !instValid
    ) else $error("instruction presented right after a redirect");

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             systemEn,
    input  logic             instValid,
    input  corePkg::dataT    instWord,
    input  corePkg::pcT      instPc,
    output logic             fetchHold,
    output corePkg::regAddrT readAddrA,
    output corePkg::regAddrT readAddrB,
    input  corePkg::dataT    readDataA,
    input  corePkg::dataT    readDataB,
    input  logic             wrEn,
    input  corePkg::regAddrT wrAddr,
    input  corePkg::dataT    wrData,
    input  logic             redirectValid,
    output logic             issueValid,
    output isaPkg::majorOpE  issueOp,
    output isaPkg::aluOpE    issueAluOp,
    output corePkg::regAddrT issueDest,
    output corePkg::dataT    issueDataA,
    output corePkg::dataT    issueDataB,
    output isaPkg::immT      issueImm,
    output corePkg::pcT      issuePc,
    output logic             haltOut
);

    isaPkg::instFieldsT fields;
    isaPkg::immT        imm;
    isaPkg::aluOpE      aluOp;
    corePkg::dataT      fwdDataA;
    corePkg::dataT      fwdDataB;
    corePkg::dataT      operandB;
    logic               controlHold;
    logic               halted;
    logic               issueFire;
    logic               isControl;
    logic               isHalt;

    assign fields    = isaPkg::instFieldsT'(instWord);
    assign imm       = instWord[7:0];
    assign readAddrA = fields.regA;
    assign readAddrB = fields.regB;

    // The execute write lands at the end of this cycle, so take it directly
    assign fwdDataA = (wrEn && wrAddr == readAddrA) ? wrData : readDataA;
    assign fwdDataB = (wrEn && wrAddr == readAddrB) ? wrData : readDataB;

    // B operand is a register for ALU and jump, otherwise the immediate
    always_comb begin
        operandB = corePkg::dataT'(imm);
        aluOp    = isaPkg::aluAdd;
        case (fields.op)
            isaPkg::opAlu: begin
                operandB = fwdDataB;
                aluOp    = fields.aluOp;
            end
            isaPkg::opJumpLink: operandB = fwdDataB;
            default:            operandB = corePkg::dataT'(imm);
        endcase
    end

    assign isControl = (fields.op == isaPkg::opBranchZero) || (fields.op == isaPkg::opJumpLink);
    assign isHalt    = (fields.op == isaPkg::opHalt);

    assign fetchHold = controlHold || halted;
    assign issueFire = instValid && systemEn && !fetchHold;

    // Halt itself never enters the issue buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid  <= 1'b0;
            controlHold <= 1'b0;
            halted      <= 1'b0;
        end else begin
            issueValid <= issueFire && !isHalt;
            if (issueFire && isControl) begin
                controlHold <= 1'b1;
            end else if (redirectValid) begin
                controlHold <= 1'b0;
            end
            if (issueFire && isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            issueOp    <= fields.op;
            issueAluOp <= aluOp;
            issueDest  <= fields.regA;
            issueDataA <= fwdDataA;
            issueDataB <= operandB;
            issueImm   <= imm;
            issuePc    <= instPc;
        end
    end

    // Last issued item has executed once the buffer is empty
    assign haltOut = halted && !issueValid;

    noIssueOnHold: assert property (
        @(posedge clk) disable iff (rst)
        fetchHold |=> !issueValid
    ) else $error("instruction issued while fetch was held");

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic             issueValid,
    input  isaPkg::majorOpE  issueOp,
    input  isaPkg::aluOpE    issueAluOp,
    input  corePkg::regAddrT issueDest,
    input  corePkg::dataT    issueDataA,
    input  corePkg::dataT    issueDataB,
    input  isaPkg::immT      issueImm,
    input  corePkg::pcT      issuePc,
    output logic             wrEn,
    output corePkg::regAddrT wrAddr,
    output corePkg::dataT    wrData,
    output logic             redirectValid,
    output corePkg::pcT      redirectPc
);

    corePkg::dataT aluResult;
    corePkg::dataT luiValue;
    corePkg::dataT linkValue;
    corePkg::pcT   nextPc;
    corePkg::pcT   branchTarget;
    logic          isZero;

    always_comb begin
        case (issueAluOp)
            isaPkg::aluAdd:   aluResult = issueDataA + issueDataB;
            isaPkg::aluSub:   aluResult = issueDataA - issueDataB;
            isaPkg::aluAnd:   aluResult = issueDataA & issueDataB;
            isaPkg::aluOr:    aluResult = issueDataA | issueDataB;
            isaPkg::aluXor:   aluResult = issueDataA ^ issueDataB;
            // Shift amount is the low nibble of B
            isaPkg::aluShl:   aluResult = issueDataA << issueDataB[3:0];
            isaPkg::aluShr:   aluResult = issueDataA >> issueDataB[3:0];
            isaPkg::aluPassB: aluResult = issueDataB;
            default:          aluResult = issueDataB;
        endcase
    end

    assign luiValue  = corePkg::dataT'(issueImm) << 8;
    assign nextPc    = issuePc + corePkg::pcT'(1);
    assign linkValue = corePkg::dataT'(nextPc);
    assign isZero    = (issueDataA == '0);

    // Branch offset is sign extended to the pc width
    assign branchTarget = issuePc + corePkg::pcT'(signed'(issueImm));

    assign wrAddr = issueDest;

    // Branches redirect even when not taken because decode waits for the redirect
    always_comb begin
        wrEn          = 1'b0;
        wrData        = aluResult;
        redirectValid = 1'b0;
        redirectPc    = nextPc;
        if (issueValid) begin
            case (issueOp)
                isaPkg::opAlu,
                isaPkg::opAluImm: wrEn = 1'b1;
                isaPkg::opLui: begin
                    wrEn   = 1'b1;
                    wrData = luiValue;
                end
                isaPkg::opBranchZero: begin
                    redirectValid = 1'b1;
                    redirectPc    = isZero ? branchTarget : nextPc;
                end
                isaPkg::opJumpLink: begin
                    wrEn          = 1'b1;
                    wrData        = linkValue;
                    redirectValid = 1'b1;
                    redirectPc    = corePkg::pcT'(issueDataB);
                end
                default: wrEn = 1'b0;
            endcase
        end
    end

endmodule

// File: src/cpuCore.sv
`timescale 1ns/1ns

module cpuCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             systemEn,
    input  logic             instFlashEn,
    input  corePkg::pcT      flashAddr,
    input  corePkg::dataT    flashData,
    output logic             haltOut,
    output logic             regWriteEn,
    output corePkg::regAddrT regWriteAddr,
    output corePkg::dataT    regWriteData
);

    // Fetch to decode
    logic          instValid;
    corePkg::dataT instWord;
    corePkg::pcT   instPc;
    logic          fetchHold;

    // Decode and register file
    corePkg::regAddrT readAddrA;
    corePkg::regAddrT readAddrB;
    corePkg::dataT    readDataA;
    corePkg::dataT    readDataB;

    // Issue buffer
    logic             issueValid;
    isaPkg::majorOpE  issueOp;
    isaPkg::aluOpE    issueAluOp;
    corePkg::regAddrT issueDest;
    corePkg::dataT    issueDataA;
    corePkg::dataT    issueDataB;
    isaPkg::immT      issueImm;
    corePkg::pcT      issuePc;

    // Execute write port and redirect
    logic             wrEn;
    corePkg::regAddrT wrAddr;
    corePkg::dataT    wrData;
    logic             redirectValid;
    corePkg::pcT      redirectPc;

    fetchStage fetchUnit (
        .clk          (clk),
        .rst          (rst),
        .systemEn     (systemEn),
        .instFlashEn  (instFlashEn),
        .flashAddr    (flashAddr),
        .flashData    (flashData),
        .fetchHold    (fetchHold),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .instValid    (instValid),
        .instWord     (instWord),
        .instPc       (instPc)
    );

    decodeStage decodeUnit (
        .clk          (clk),
        .rst          (rst),
        .systemEn     (systemEn),
        .instValid    (instValid),
        .instWord     (instWord),
        .instPc       (instPc),
        .fetchHold    (fetchHold),
        .readAddrA    (readAddrA),
        .readAddrB    (readAddrB),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .wrEn         (wrEn),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .redirectValid(redirectValid),
        .issueValid   (issueValid),
        .issueOp      (issueOp),
        .issueAluOp   (issueAluOp),
        .issueDest    (issueDest),
        .issueDataA   (issueDataA),
        .issueDataB   (issueDataB),
        .issueImm     (issueImm),
        .issuePc      (issuePc),
        .haltOut      (haltOut)
    );

    registerFile regFile (
        .clk      (clk),
        .rst      (rst),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData)
    );

    executeStage executeUnit (
        .issueValid   (issueValid),
        .issueOp      (issueOp),
        .issueAluOp   (issueAluOp),
        .issueDest    (issueDest),
        .issueDataA   (issueDataA),
        .issueDataB   (issueDataB),
        .issueImm     (issueImm),
        .issuePc      (issuePc),
        .wrEn         (wrEn),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc)
    );

    // Observation of every register write
    assign regWriteEn   = wrEn;
    assign regWriteAddr = wrAddr;
    assign regWriteData = wrData;

endmodule

// File: tests/cpuCoreTb.sv
`timescale 1ns/1ns

module cpuCoreTb;

    localparam int GoldenDepth = 512;

    logic             clk;
    logic             rst;
    logic             systemEn;
    logic             instFlashEn;
    corePkg::pcT      flashAddr;
    corePkg::dataT    flashData;
    logic             haltOut;
    logic             regWriteEn;
    corePkg::regAddrT regWriteAddr;
    corePkg::dataT    regWriteData;

    logic [19:0] golden [GoldenDepth];
    logic [19:0] seenWrites [$];
    logic        haltSeen;
    int          lateWrites;
    int          haltDrops;
    int          errorCount;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    cpuCore u_cpuCore (
        .clk         (clk),
        .rst         (rst),
        .systemEn    (systemEn),
        .instFlashEn (instFlashEn),
        .flashAddr   (flashAddr),
        .flashData   (flashData),
        .haltOut     (haltOut),
        .regWriteEn  (regWriteEn),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Stops a run where some program never reaches its halt
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: haltOut never rose within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Write log in program order with counts of writes and haltOut drops after halt
    always @(negedge clk) begin
        if (rst) begin
            seenWrites.delete();
            lateWrites <= 0;
            haltDrops  <= 0;
            haltSeen   <= 1'b0;
        end else begin
            if (regWriteEn) begin
                seenWrites.push_back({regWriteAddr, regWriteData});
                if (haltSeen || haltOut) begin
                    lateWrites <= lateWrites + 1;
                end
            end
            if (haltOut) begin
                haltSeen <= 1'b1;
            end else if (haltSeen) begin
                haltDrops <= haltDrops + 1;
            end
        end
    end

    task automatic checkValue(input string name, input logic [19:0] expected,
                              input logic [19:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // Flash one record under reset, run it to halt and compare its writes
    task automatic runTest(input int index, input int start, input bit withStall,
                           output bit passed);
        string name;
        int    progLen;
        int    writeCount;
        int    errorsBefore;
        int    cyc;
        name = $sformatf("test %0d%s", index, withStall ? " stalled" : "");
        progLen = int'(golden[start]);
        writeCount = int'(golden[start + progLen + 1]);
        errorsBefore = errorCount;
        stepCycle();
        rst = 1'b1;
        systemEn = 1'b0;
        for (int i = 0; i < progLen; i++) begin
            instFlashEn = 1'b1;
            flashAddr = corePkg::pcT'(i);
            flashData = golden[start + 1 + i][15:0];
            stepCycle();
        end
        instFlashEn = 1'b0;
        repeat (5) stepCycle();
        rst = 1'b0;
        stepCycle();
        systemEn = 1'b1;
        cyc = 0;
        while (!haltOut) begin
            stepCycle();
            cyc++;
            // Pause the core for five cycles in the middle of the program
            systemEn = !(withStall && cyc >= 3 && cyc < 8);
        end
        repeat (8) stepCycle();
        checkValue({name, " write count"}, 20'(writeCount), 20'(seenWrites.size()));
        for (int i = 0; i < writeCount && i < seenWrites.size(); i++) begin
            checkValue($sformatf("%s write %0d", name, i),
                       golden[start + progLen + 2 + i], seenWrites[i]);
        end
        if (lateWrites != 0) begin
            $display("Error %s: a register write came after haltOut rose", name);
            errorCount++;
        end
        if (haltDrops != 0) begin
            $display("Error %s: haltOut fell again before reset", name);
            errorCount++;
        end
        passed = (errorCount == errorsBefore);
        $display("%s: %s", name, passed ? "passed" : "failed");
    endtask

    initial begin
        int starts [$];
        int pos;
        int numWords;
        int passCount;
        bit passed;
        rst = 1'b1;
        systemEn = 1'b0;
        instFlashEn = 1'b0;
        flashAddr = '0;
        flashData = '0;
        errorCount = 0;
        passCount = 0;
        numWords = 0;
        pos = 0;
        $readmemh("tests/program_golden.hex", golden);
        while (pos < GoldenDepth && golden[pos] != 20'h0) begin
            starts.push_back(pos);
            numWords += int'(golden[pos]);
            pos += int'(golden[pos]) + int'(golden[pos + int'(golden[pos]) + 1]) + 2;
        end
        // Each record runs twice with the second run stalled
        cycleLimit = 2 * (20 * numWords + 100 * starts.size());
        if (starts.size() == 0) begin
            $display("Error: the golden file holds no test records");
            errorCount++;
        end
        foreach (starts[t]) begin
            runTest(t + 1, starts[t], 1'b0, passed);
            if (passed) begin
                passCount++;
            end
            runTest(t + 1, starts[t], 1'b1, passed);
            if (passed) begin
                passCount++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", 2 * starts.size(),
                 passCount, 2 * starts.size() - passCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/program_golden.hex
// Record: program length, program words, write count, expected writes
// Expected write holds the register in bits 19..16 and the data in bits 15..0
// ALU, immediate and upper-immediate operations
0000C
02134 03212 02305 01210 01421 01432 01124 01313 01235 01236 01427 0F000
0000B
10034 21200 30005 21234 4EDCC 40004 11200 31205 24680 20234 40234
// Dependent chain with wraparound
00008
035FF 025FF 02501 02607 01560 01650 01561 0F000
00007
5FF00 5FFFF 50000 60007 50007 6000E 5FFF9
// Taken, not-taken and backward branches
0000C
02703 04803 02911 02922 04702 02A05 02C01 02B03 01BC1 04B02 04DFE 0F000
00007
70003 A0005 C0001 B0003 B0002 B0001 B0000
// Call and return through jump-and-link
00008
02E06 05FE0 02201 0F000 02333 02333 02108 05FF0
00005
E0006 F0002 10008 F0008 20001
// Halt stops issue ahead of the words behind it
00005
00000 02342 0F000 02301 03455
00001
30042
// Zero length ends the list
00000

// File: sources.f
+incdir+src
src/isaPkg.sv
src/corePkg.sv
src/registerFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/cpuCore.sv
tests/cpuCoreTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --assert --timing
TOP       = cpuCoreTb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
